//--- src/lb_macros.svh
`ifndef LB_MACROS_SVH
`define LB_MACROS_SVH

//////////////////////////////////////////////////
// Width constants for the line fill buffer.
//////////////////////////////////////////////////

// Byte address width.
`define LB_AW 32

// Log2 of the memory bus width in bytes.
// 8 bytes per refill beat.
`define LB_BUS_P_BYTES 3

// Log2 of the line width in bytes.
// 16 bytes per line, two beats.
`define LB_LINE_P_BYTES 4

// Log2 of the CPU port width in bytes.
// 4 bytes per load or store.
`define LB_CPU_P_BYTES 2

`endif

//--- src/lb_pkg.sv
`default_nettype none

`include "lb_macros.svh"

package lb_pkg;

   //////////////////////////////////////////////////
   // Address views.
   //////////////////////////////////////////////////

   // Tag and line offset split of a byte address.
   // Tag in the upper bits, offset in the low bits.
   typedef struct packed {
      logic [`LB_AW-`LB_LINE_P_BYTES-1:0] tag;
      logic [`LB_LINE_P_BYTES-1:0]        offset;
   } addr_fields_t;

   // Same byte address, raw or split.
   // Raw view feeds the aligners, split view the tag compare.
   typedef union packed {
      logic [`LB_AW-1:0] raw;
      addr_fields_t      f;
   } addr_u;

   //////////////////////////////////////////////////
   // Request and write structs.
   //////////////////////////////////////////////////

   // One refill beat from the memory bus.
   typedef struct packed {
      addr_u                                addr;
      logic [(1<<`LB_BUS_P_BYTES)*8-1:0]    data;
      logic [(1<<`LB_BUS_P_BYTES)-1:0]      be;
   } refill_beat_t;

   // One CPU store.
   typedef struct packed {
      addr_u                                addr;
      logic [(1<<`LB_CPU_P_BYTES)*8-1:0]    data;
      logic [(1<<`LB_CPU_P_BYTES)-1:0]      be;
   } store_req_t;

   // Line-wide write after alignment.
   // Data copied to all lanes, mask marks the live bytes.
   typedef struct packed {
      logic [(1<<`LB_LINE_P_BYTES)*8-1:0]   data;
      logic [(1<<`LB_LINE_P_BYTES)-1:0]     mask;
   } line_wr_t;

endpackage

`default_nettype wire

//--- src/align_r.sv
`default_nettype none

module align_r
#(
   parameter IN_P_DW_BYTES  = 0,
   parameter IN_AW          = 0,
   parameter OUT_P_DW_BYTES = 0
)
(
   input  wire logic [(1<<IN_P_DW_BYTES)*8-1:0]   i_in_rdat,
   input  wire logic [(1<<IN_P_DW_BYTES)-1:0]     i_in_rbe,
   input  wire logic [IN_AW-1:0]                  i_in_addr,
   output logic      [(1<<OUT_P_DW_BYTES)-1:0]    o_out_wmsk,
   output logic      [(1<<OUT_P_DW_BYTES)*8-1:0]  o_out_din
);

   // Byte counts of both sides.
   localparam IN_BYTES  = (1<<IN_P_DW_BYTES);
   localparam OUT_BYTES = (1<<OUT_P_DW_BYTES);

   generate
      //////////////////////////////////////////////////
      // Same width.
      //////////////////////////////////////////////////
      if (OUT_P_DW_BYTES == IN_P_DW_BYTES)
      begin : gen_pass
         assign o_out_din  = i_in_rdat;
         assign o_out_wmsk = i_in_rbe;
      end
      //////////////////////////////////////////////////
      // Narrowing, pick one window.
      //////////////////////////////////////////////////
      else if (OUT_P_DW_BYTES < IN_P_DW_BYTES)
      begin : gen_narrow
         localparam WIN_NUM   = (IN_BYTES/OUT_BYTES);
         localparam WIN_P_NUM = (IN_P_DW_BYTES - OUT_P_DW_BYTES);
         localparam WIN_DW    = (OUT_BYTES*8);

         logic [WIN_DW-1:0]    rdat_win [WIN_NUM];
         logic [OUT_BYTES-1:0] rbe_win  [WIN_NUM];
         logic [WIN_P_NUM-1:0] win_sel;

         // Window index sits just above the output byte offset.
         assign win_sel = i_in_addr[OUT_P_DW_BYTES +: WIN_P_NUM];

         // Slice input into output-sized windows.
         always_comb
         begin
            for (int k = 0; k < WIN_NUM; k++)
            begin
               rdat_win[k] = i_in_rdat[k*WIN_DW +: WIN_DW];
               rbe_win[k]  = i_in_rbe[k*OUT_BYTES +: OUT_BYTES];
            end
         end

         assign o_out_din  = rdat_win[win_sel];
         assign o_out_wmsk = rbe_win[win_sel];
      end
      //////////////////////////////////////////////////
      // Widening, replicate data.
      //////////////////////////////////////////////////
      else
      begin : gen_widen
         localparam WIN_NUM   = (OUT_BYTES/IN_BYTES);
         localparam WIN_P_NUM = (OUT_P_DW_BYTES - IN_P_DW_BYTES);
         localparam WIN_DW    = (IN_BYTES*8);

         logic [WIN_P_NUM-1:0] lane_sel;

         // Lane index sits just above the input byte offset.
         assign lane_sel = i_in_addr[IN_P_DW_BYTES +: WIN_P_NUM];

         // Data lands on every lane.
         // Enables only on the addressed lane.
         always_comb
         begin
            for (int k = 0; k < WIN_NUM; k++)
            begin
               o_out_din[k*WIN_DW +: WIN_DW] = i_in_rdat;
               if (lane_sel == WIN_P_NUM'(k))
                  o_out_wmsk[k*IN_BYTES +: IN_BYTES] = i_in_rbe;
               else
                  o_out_wmsk[k*IN_BYTES +: IN_BYTES] = '0;
            end
         end
      end
   endgenerate

endmodule

`default_nettype wire

//--- src/line_buffer.sv
`default_nettype none

`include "lb_macros.svh"

module line_buffer
(
   input  wire                                      clk,
   input  wire                                      i_rst,
   // Refill side.
   input  wire logic                                i_fill_start,
   input  wire logic [`LB_AW-`LB_LINE_P_BYTES-1:0]  i_fill_tag,
   input  wire logic                                i_fill_wr_valid,
   input  wire lb_pkg::line_wr_t                    i_fill_wr,
   // Store side.
   input  wire logic                                i_st_valid,
   input  wire lb_pkg::addr_u                       i_st_addr,
   input  wire lb_pkg::line_wr_t                    i_st_wr,
   // Load side.
   input  wire logic                                i_ld_valid,
   input  wire lb_pkg::addr_u                       i_ld_addr,
   output logic                                     o_ld_valid,
   output logic                                     o_ld_hit,
   output logic      [(1<<`LB_CPU_P_BYTES)*8-1:0]   o_ld_data
);

   // Derived sizes.
   localparam TAG_W      = `LB_AW - `LB_LINE_P_BYTES;
   localparam LINE_BYTES = (1<<`LB_LINE_P_BYTES);
   localparam CPU_BYTES  = (1<<`LB_CPU_P_BYTES);

   //////////////////////////////////////////////////
   // Line state.
   //////////////////////////////////////////////////

   // Tag of the line being filled.
   logic [TAG_W-1:0]        tag_q;
   // Line bytes, no reset.
   logic [LINE_BYTES*8-1:0] line_q;
   // One valid bit per byte.
   logic [LINE_BYTES-1:0]   vld_q;

   // Next-state terms.
   logic [LINE_BYTES*8-1:0] line_nxt;
   logic [LINE_BYTES-1:0]   vld_nxt;
   logic [LINE_BYTES-1:0]   vld_base;

   // Gated write masks.
   logic                    st_hit;
   logic [LINE_BYTES-1:0]   fill_msk;
   logic [LINE_BYTES-1:0]   st_msk;

   // Load lookup.
   logic [CPU_BYTES*8-1:0]  ld_word;
   logic [CPU_BYTES-1:0]    ld_vld;
   logic                    ld_tag_eq;
   logic                    ld_hit;

   //////////////////////////////////////////////////
   // Write merge.
   //////////////////////////////////////////////////

   // Store compares against the current tag.
   // A fill start in the same cycle does not move it yet.
   assign st_hit = i_st_valid & (i_st_addr.f.tag == tag_q);

   // Each stream gated by its own strobe.
   assign fill_msk = i_fill_wr_valid ? i_fill_wr.mask : '0;
   assign st_msk   = st_hit ? i_st_wr.mask : '0;

   // Fill start drops every valid bit.
   assign vld_base = i_fill_start ? '0 : vld_q;

   // Refill bytes become valid.
   // Stores only replace data, mask unchanged.
   assign vld_nxt = vld_base | fill_msk;

   // Byte merge, store wins over refill.
   always_comb
   begin
      line_nxt = line_q;
      for (int b = 0; b < LINE_BYTES; b++)
      begin
         if (st_msk[b])
            line_nxt[b*8 +: 8] = i_st_wr.data[b*8 +: 8];
         else if (fill_msk[b])
            line_nxt[b*8 +: 8] = i_fill_wr.data[b*8 +: 8];
      end
   end

   // Control state.
   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         tag_q <= '0;
         vld_q <= '0;
      end
      else
      begin
         // New fill takes the new tag.
         if (i_fill_start)
            tag_q <= i_fill_tag;
         vld_q <= vld_nxt;
      end
   end

   // Payload.
   always_ff @(posedge clk)
   begin
      line_q <= line_nxt;
   end

   //////////////////////////////////////////////////
   // Load path.
   //////////////////////////////////////////////////

   // Narrow line and valid mask to one CPU word.
   // Word picked by address bits 3:2.
   align_r
   #(
      .IN_P_DW_BYTES  (`LB_LINE_P_BYTES),
      .IN_AW          (`LB_AW),
      .OUT_P_DW_BYTES (`LB_CPU_P_BYTES)
   )
   u_ld_align
   (
      .i_in_rdat  (line_q),
      .i_in_rbe   (vld_q),
      .i_in_addr  (i_ld_addr.raw),
      .o_out_wmsk (ld_vld),
      .o_out_din  (ld_word)
   );

   // Hit needs the tag and all four bytes.
   assign ld_tag_eq = (i_ld_addr.f.tag == tag_q);
   assign ld_hit    = ld_tag_eq & (&ld_vld);

   // Response flags, one cycle after the request.
   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         o_ld_valid <= 1'b0;
         o_ld_hit   <= 1'b0;
      end
      else
      begin
         o_ld_valid <= i_ld_valid;
         o_ld_hit   <= i_ld_valid & ld_hit;
      end
   end

   // Response data.
   // held when no load is issued
   always_ff @(posedge clk)
   begin
      if (i_ld_valid)
         o_ld_data <= ld_word;
   end

endmodule

`default_nettype wire

//--- src/fill_store_top.sv
`default_nettype none

`include "lb_macros.svh"

module fill_store_top
(
   input  wire                                     clk,
   input  wire                                     i_rst,
   // Refill.
   input  wire logic                               i_fill_start,
   input  wire lb_pkg::addr_u                      i_fill_addr,
   input  wire logic                               i_beat_valid,
   input  wire lb_pkg::refill_beat_t               i_beat,
   // Store.
   input  wire logic                               i_st_valid,
   input  wire lb_pkg::store_req_t                 i_st,
   // Load.
   input  wire logic                               i_ld_valid,
   input  wire lb_pkg::addr_u                      i_ld_addr,
   output logic                                    o_ld_valid,
   output logic                                    o_ld_hit,
   output logic      [(1<<`LB_CPU_P_BYTES)*8-1:0]  o_ld_data
);

   //////////////////////////////////////////////////
   // Aligned write streams.
   //////////////////////////////////////////////////

   wire [(1<<`LB_LINE_P_BYTES)*8-1:0] fill_din;
   wire [(1<<`LB_LINE_P_BYTES)-1:0]   fill_msk;
   wire [(1<<`LB_LINE_P_BYTES)*8-1:0] st_din;
   wire [(1<<`LB_LINE_P_BYTES)-1:0]   st_msk;
   wire lb_pkg::line_wr_t             fill_wr;
   wire lb_pkg::line_wr_t             st_wr;

   // Refill beat, 64 to 128 bits.
   // Address bit 3 picks the half.
   align_r
   #(
      .IN_P_DW_BYTES  (`LB_BUS_P_BYTES),
      .IN_AW          (`LB_AW),
      .OUT_P_DW_BYTES (`LB_LINE_P_BYTES)
   )
   u_fill_align
   (
      .i_in_rdat  (i_beat.data),
      .i_in_rbe   (i_beat.be),
      .i_in_addr  (i_beat.addr.raw),
      .o_out_wmsk (fill_msk),
      .o_out_din  (fill_din)
   );

   // Store, 32 to 128 bits.
   // Address bits 3:2 pick the word.
   align_r
   #(
      .IN_P_DW_BYTES  (`LB_CPU_P_BYTES),
      .IN_AW          (`LB_AW),
      .OUT_P_DW_BYTES (`LB_LINE_P_BYTES)
   )
   u_st_align
   (
      .i_in_rdat  (i_st.data),
      .i_in_rbe   (i_st.be),
      .i_in_addr  (i_st.addr.raw),
      .o_out_wmsk (st_msk),
      .o_out_din  (st_din)
   );

   assign fill_wr = '{data: fill_din, mask: fill_msk};
   assign st_wr   = '{data: st_din, mask: st_msk};

   //////////////////////////////////////////////////
   // Line buffer.
   //////////////////////////////////////////////////

   // Fill tag comes from the fill start address.
   line_buffer u_line_buffer
   (
      .clk             (clk),
      .i_rst           (i_rst),
      .i_fill_start    (i_fill_start),
      .i_fill_tag      (i_fill_addr.f.tag),
      .i_fill_wr_valid (i_beat_valid),
      .i_fill_wr       (fill_wr),
      .i_st_valid      (i_st_valid),
      .i_st_addr       (i_st.addr),
      .i_st_wr         (st_wr),
      .i_ld_valid      (i_ld_valid),
      .i_ld_addr       (i_ld_addr),
      .o_ld_valid      (o_ld_valid),
      .o_ld_hit        (o_ld_hit),
      .o_ld_data       (o_ld_data)
   );

endmodule

`default_nettype wire

//--- tb/tb_top.sv
`default_nettype none

`include "lb_macros.svh"

module tb_top;

   localparam TAG_W = `LB_AW - `LB_LINE_P_BYTES;

   // Cycle budget of reset and of each test.
   localparam RST_CYC   = 5;
   localparam T1_CYC    = 10;
   localparam T2_CYC    = 12;
   localparam T3_CYC    = 12;
   localparam T4_CYC    = 40;
   localparam T5_CYC    = 30;
   localparam MARGIN    = 40;
   localparam CYC_LIMIT = RST_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + MARGIN;

   // Tags used by the tests.
   localparam [TAG_W-1:0] TAG_A = 28'h1234567;
   localparam [TAG_W-1:0] TAG_B = 28'h0abcdef;
   localparam [TAG_W-1:0] TAG_C = 28'h7654321;
   localparam [TAG_W-1:0] TAG_D = 28'h0c443a5;

   // DUT ports.
   logic                 clk;
   logic                 i_rst;
   logic                 i_fill_start;
   lb_pkg::addr_u        i_fill_addr;
   logic                 i_beat_valid;
   lb_pkg::refill_beat_t i_beat;
   logic                 i_st_valid;
   lb_pkg::store_req_t   i_st;
   logic                 i_ld_valid;
   lb_pkg::addr_u        i_ld_addr;
   logic                 o_ld_valid;
   logic                 o_ld_hit;
   logic [31:0]          o_ld_data;

   // Shadow line state.
   logic [TAG_W-1:0] m_tag;
   logic [127:0]     m_line;
   logic [15:0]      m_mask;
   // Predicted load response.
   logic             exp_valid;
   logic             exp_hit;
   logic [31:0]      exp_data;

   integer seed;
   integer err_cnt   = 0;
   integer ld_cnt    = 0;
   integer cycle_cnt = 0;
   integer test_num  = 1;
   integer err_mark;
   integer ld_mark;

   fill_store_top uut
   (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_fill_start (i_fill_start),
      .i_fill_addr  (i_fill_addr),
      .i_beat_valid (i_beat_valid),
      .i_beat       (i_beat),
      .i_st_valid   (i_st_valid),
      .i_st         (i_st),
      .i_ld_valid   (i_ld_valid),
      .i_ld_addr    (i_ld_addr),
      .o_ld_valid   (o_ld_valid),
      .o_ld_hit     (o_ld_hit),
      .o_ld_data    (o_ld_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Shadow model.
   //////////////////////////////////////////////////

   always @(posedge clk)
   begin : shadow_model
      logic [1:0]   wsel;
      logic         hsel;
      logic [1:0]   ssel;
      logic [127:0] nline;
      logic [15:0]  nmask;
      if (i_rst)
      begin
         m_tag     <= '0;
         m_mask    <= '0;
         m_line    <= '0;
         exp_valid <= 1'b0;
         exp_hit   <= 1'b0;
      end
      else
      begin
         // Load sees the line as it was before this edge.
         wsel = i_ld_addr.raw[3:2];
         exp_valid <= i_ld_valid;
         exp_hit   <= i_ld_valid && (i_ld_addr.f.tag == m_tag) && (&m_mask[wsel*4 +: 4]);
         if (i_ld_valid)
            exp_data <= m_line[wsel*32 +: 32];
         nline = m_line;
         nmask = m_mask;
         // Fill start clears the mask.
         if (i_fill_start)
            nmask = '0;
         // Beat bytes land in the half picked by bit 3.
         if (i_beat_valid)
         begin
            hsel = i_beat.addr.raw[3];
            for (int i = 0; i < 8; i++)
            begin
               if (i_beat.be[i])
               begin
                  nline[(hsel*8+i)*8 +: 8] = i_beat.data[i*8 +: 8];
                  nmask[hsel*8+i]          = 1'b1;
               end
            end
         end
         // Store goes last and checks the old tag.
         if (i_st_valid && (i_st.addr.f.tag == m_tag))
         begin
            ssel = i_st.addr.raw[3:2];
            for (int i = 0; i < 4; i++)
            begin
               if (i_st.be[i])
                  nline[(ssel*4+i)*8 +: 8] = i_st.data[i*8 +: 8];
            end
         end
         if (i_fill_start)
            m_tag <= i_fill_addr.f.tag;
         m_line <= nline;
         m_mask <= nmask;
      end
   end

   //////////////////////////////////////////////////
   // Response checks.
   //////////////////////////////////////////////////

   chk_ld_valid: assert property (@(posedge clk) disable iff (i_rst) o_ld_valid == exp_valid)
   else
   begin
      err_cnt = err_cnt + 1;
      $display("CHECK FAILED at %0t: o_ld_valid is %b, expected %b",
               $time, $sampled(o_ld_valid), $sampled(exp_valid));
   end

   chk_ld_hit: assert property (@(posedge clk) disable iff (i_rst) o_ld_hit == exp_hit)
   else
   begin
      err_cnt = err_cnt + 1;
      $display("CHECK FAILED at %0t: o_ld_hit is %b, expected %b",
               $time, $sampled(o_ld_hit), $sampled(exp_hit));
   end

   // Data only matters on a hit.
   chk_ld_data: assert property (@(posedge clk) disable iff (i_rst)
                                 exp_hit |-> o_ld_data == exp_data)
   else
   begin
      err_cnt = err_cnt + 1;
      $display("CHECK FAILED at %0t: o_ld_data is %h, expected %h",
               $time, $sampled(o_ld_data), $sampled(exp_data));
   end

   //////////////////////////////////////////////////
   // Stimulus tasks.
   //////////////////////////////////////////////////

   // One edge with all strobes dropped.
   task next_cycle;
      @(posedge clk);
      i_fill_start <= 1'b0;
      i_beat_valid <= 1'b0;
      i_st_valid   <= 1'b0;
      i_ld_valid   <= 1'b0;
   endtask

   task drive_load(input logic [31:0] a);
      i_ld_valid    <= 1'b1;
      i_ld_addr.raw <= a;
      ld_cnt = ld_cnt + 1;
   endtask

   task drive_fill_start(input logic [TAG_W-1:0] tag);
      i_fill_start    <= 1'b1;
      i_fill_addr.raw <= {tag, 4'h0};
   endtask

   task drive_beat(input logic [31:0] a, input logic [63:0] d, input logic [7:0] be);
      i_beat_valid    <= 1'b1;
      i_beat.addr.raw <= a;
      i_beat.data     <= d;
      i_beat.be       <= be;
   endtask

   task drive_store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
      i_st_valid    <= 1'b1;
      i_st.addr.raw <= a;
      i_st.data     <= d;
      i_st.be       <= be;
   endtask

   // Fill start then low and high beats.
   task fill_line(input logic [TAG_W-1:0] tag, input logic [7:0] be_lo, input logic [7:0] be_hi);
      next_cycle();
      drive_fill_start(tag);
      next_cycle();
      drive_beat({tag, 4'h0}, {$random(seed), $random(seed)}, be_lo);
      next_cycle();
      drive_beat({tag, 4'h8}, {$random(seed), $random(seed)}, be_hi);
   endtask

   task read_all_words(input logic [TAG_W-1:0] tag);
      for (int w = 0; w < 4; w++)
      begin
         next_cycle();
         drive_load({tag, 2'(w), 2'b00});
      end
   endtask

   // Last response lands one edge later.
   // Its check has run by the next falling edge.
   task drain_responses;
      next_cycle();
      next_cycle();
      @(negedge clk);
   endtask

   task report_test(input string name);
      $display("test %0d %s: %0d loads, %0d errors",
               test_num, name, ld_cnt - ld_mark, err_cnt - err_mark);
      test_num = test_num + 1;
      err_mark = err_cnt;
      ld_mark  = ld_cnt;
   endtask

   //////////////////////////////////////////////////
   // Test sequence.
   //////////////////////////////////////////////////

   initial
   begin
      logic [1:0]  w;
      logic [31:0] r;
      seed         = 32'hc443;
      i_rst        = 1'b1;
      i_fill_start = 1'b0;
      i_fill_addr  = '0;
      i_beat_valid = 1'b0;
      i_beat       = '0;
      i_st_valid   = 1'b0;
      i_st         = '0;
      i_ld_valid   = 1'b0;
      i_ld_addr    = '0;
      err_mark     = 0;
      ld_mark      = 0;
      repeat (RST_CYC) @(posedge clk);
      i_rst <= 1'b0;

      // Empty line misses even for tag zero.
      read_all_words('0);
      drain_responses();
      report_test("loads after reset miss");

      fill_line(TAG_A, 8'hff, 8'hff);
      read_all_words(TAG_A);
      drain_responses();
      report_test("full fill, all words hit");

      // Byte 1 and byte 12 never arrive.
      fill_line(TAG_B, 8'hfd, 8'hef);
      read_all_words(TAG_B);
      drain_responses();
      report_test("partial fill");

      fill_line(TAG_C, 8'hff, 8'hff);
      for (int k = 0; k < 8; k++)
      begin
         r = $random(seed);
         w = r[5:4];
         next_cycle();
         drive_store({TAG_C, w, 2'b00}, $random(seed), r[3:0]);
         next_cycle();
         drive_load({TAG_C, w, 2'b00});
      end
      // Foreign tag store.
      next_cycle();
      drive_store({TAG_C ^ 28'h1, 4'h4}, $random(seed), 4'hf);
      next_cycle();
      drive_load({TAG_C, 4'h4});
      // Beat and store on word 1 together.
      next_cycle();
      drive_beat({TAG_C, 4'h0}, {$random(seed), $random(seed)}, 8'hff);
      drive_store({TAG_C, 4'h4}, $random(seed), 4'hf);
      read_all_words(TAG_C);
      drain_responses();
      report_test("stores merge by byte");

      // New tag and high beat in one cycle.
      // A store to the old tag there still hits word 2.
      next_cycle();
      drive_fill_start(TAG_D);
      drive_beat({TAG_D, 4'h8}, {$random(seed), $random(seed)}, 8'hff);
      drive_store({TAG_C, 4'h8}, $random(seed), 4'hf);
      read_all_words(TAG_C);
      next_cycle();
      drive_beat({TAG_D, 4'h0}, {$random(seed), $random(seed)}, 8'hff);
      read_all_words(TAG_D);
      // Back to back loads on old and new tags.
      for (int k = 0; k < 8; k++)
      begin
         r = $random(seed);
         next_cycle();
         drive_load({(r[8] ? TAG_C : TAG_D), r[3:2], 2'b00});
      end
      drain_responses();
      report_test("refill with new tag, back-to-back loads");

      $display("%0d tests, %0d loads, %0d errors", test_num - 1, ld_cnt, err_cnt);
      if (err_cnt == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // Timeout.
   //////////////////////////////////////////////////

   always @(posedge clk)
      cycle_cnt <= cycle_cnt + 1;

   initial
   begin
      wait (cycle_cnt >= CYC_LIMIT);
      $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/lb_pkg.sv
src/align_r.sv
src/line_buffer.sv
src/fill_store_top.sv
tb/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build the line fill buffer testbench with Verilator and run it.
# Pass or fail comes from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --top-module tb_top -f tb.f \
   --Mdir obj_dir -o tb_sim > "$BUILD_LOG" 2>&1 \
   && ./obj_dir/tb_sim > "$SIM_LOG" 2>&1 \
   || { echo "build or simulation error, see $BUILD_LOG and $SIM_LOG"; exit 1; }

cat "$SIM_LOG"

grep -q "^All checks passed$" "$SIM_LOG" \
   && { echo "PASS"; exit 0; } \
   || { echo "FAIL"; exit 1; }
